//--- build.f
hw/ex_pkg.sv
hw/ex_pipe_reg.sv
hw/ex_alu_csr.sv
hw/ex_store_align.sv
hw/ex_stage.sv
hw/ex_top.sv
test/tb_ex_top.sv

//--- hw/ex_alu_csr.sv
// ALU and CSR unit

`timescale 1ns/1ps

module ex_alu_csr (
  input  ex_pkg::ds_to_es_t       i_inst,
  output logic [ex_pkg::XLEN-1:0] o_alu_result,
  output logic [ex_pkg::XLEN-1:0] o_csr_result
);

  import ex_pkg::*;

  logic [XLEN-1:0] src1;
  logic [XLEN-1:0] src2;
  logic [XLEN-1:0] shift_src;
  logic [5:0]      shamt;
  logic [XLEN-1:0] raw_result;

  assign src1 = i_inst.src1_is_pc ? i_inst.pc : i_inst.rs1data;

  always_comb begin
    case (i_inst.src2_sel)
      SRC2_RS2:  src2 = i_inst.rs2data;
      SRC2_IMM:  src2 = i_inst.imm;
      SRC2_FOUR: src2 = XLEN'(4);   // link address
      default:   src2 = '0;
    endcase
  end

  // word shifts only look at the low half of src1
  always_comb begin
    if (i_inst.word_cut) begin
      shift_src = {{(XLEN/2){src1[XLEN/2-1] & (i_inst.alu_op == ALU_SRA)}},
                   src1[XLEN/2-1:0]};
      shamt     = {1'b0, src2[4:0]};
    end else begin
      shift_src = src1;
      shamt     = src2[5:0];
    end
  end

  always_comb begin
    case (i_inst.alu_op)
      ALU_ADD:   raw_result = src1 + src2;
      ALU_SUB:   raw_result = src1 - src2;
      ALU_SLL:   raw_result = shift_src << shamt;
      ALU_SLT:   raw_result = {{(XLEN-1){1'b0}}, $signed(src1) < $signed(src2)};
      ALU_SLTU:  raw_result = {{(XLEN-1){1'b0}}, src1 < src2};
      ALU_XOR:   raw_result = src1 ^ src2;
      ALU_SRL:   raw_result = shift_src >> shamt;
      ALU_SRA:   raw_result = $signed(shift_src) >>> shamt;
      ALU_OR:    raw_result = src1 | src2;
      ALU_AND:   raw_result = src1 & src2;
      ALU_PASS2: raw_result = src2;    // lui
      default:   raw_result = '0;
    endcase
  end

  // w-suffix ops sign-extend bit 31
  assign o_alu_result = i_inst.word_cut ?
                        {{(XLEN/2){raw_result[XLEN/2-1]}}, raw_result[XLEN/2-1:0]} :
                        raw_result;

  always_comb begin
    case (i_inst.csr_op)
      CSR_RW:  o_csr_result = i_inst.rs1data;
      CSR_RS:  o_csr_result = i_inst.csrrdata | i_inst.rs1data;
      CSR_RC:  o_csr_result = i_inst.csrrdata & ~i_inst.rs1data;
      default: o_csr_result = '0;
    endcase
  end

endmodule

//--- hw/ex_pipe_reg.sv
// Pipeline latch

`timescale 1ns/1ps

module ex_pipe_reg #(
  parameter type payload_t = logic
) (
  input  logic     i_clk,
  input  logic     i_rst_n,
  input  logic     i_valid,
  input  payload_t i_data,
  output logic     o_allowin,
  input  logic     i_out_ready,
  output logic     o_valid,
  output payload_t o_data
);

  logic     valid_q;
  payload_t data_q;

  // empty, or the held item leaves this cycle
  assign o_allowin = !valid_q || i_out_ready;

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      valid_q <= 1'b0;
    end else if (o_allowin) begin
      valid_q <= i_valid;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_valid && o_allowin) begin
      data_q <= i_data;   // load on transfer only
    end
  end

  assign o_valid = valid_q;
  assign o_data  = data_q;

  a_valid_known: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    !$isunknown(o_valid));

endmodule

//--- hw/ex_pkg.sv
// Execute stage shared types

package ex_pkg;

  localparam int XLEN          = 64;
  localparam int SRAM_ADDR_WD  = 32;
  localparam int SRAM_WMASK_WD = 8;
  localparam int GPR_ADDR_WD   = 5;
  localparam int CSR_ADDR_WD   = 12;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_SLL,
    ALU_SLT,
    ALU_SLTU,
    ALU_XOR,
    ALU_SRL,
    ALU_SRA,
    ALU_OR,
    ALU_AND,
    ALU_PASS2
  } alu_op_e;

  // low two bits give the access size
  typedef enum logic [2:0] {
    MEM_B,
    MEM_H,
    MEM_W,
    MEM_D,
    MEM_BU,
    MEM_HU,
    MEM_WU
  } mem_op_e;

  typedef enum logic [1:0] {
    CSR_NONE,
    CSR_RW,
    CSR_RS,
    CSR_RC
  } csr_op_e;

  typedef enum logic [1:0] {
    SRC2_RS2,
    SRC2_IMM,
    SRC2_FOUR
  } src2_sel_e;

  typedef struct packed {
    logic                   load_inst;   // for load stall
    logic [XLEN-1:0]        rs1data;
    logic [XLEN-1:0]        rs2data;
    logic [XLEN-1:0]        csrrdata;
    logic [XLEN-1:0]        imm;
    logic [XLEN-1:0]        pc;
    logic                   src1_is_pc;
    src2_sel_e              src2_sel;
    logic                   word_cut;
    alu_op_e                alu_op;
    logic [GPR_ADDR_WD-1:0] rd;
    logic [CSR_ADDR_WD-1:0] csr;
    logic                   gpr_wen;
    logic                   csr_wen;
    logic                   mem_ren;
    logic                   mem_wen;
    mem_op_e                mem_op;
    logic                   csr_inst;    // rd takes the old csr value
    csr_op_e                csr_op;
  } ds_to_es_t;

  typedef struct packed {
    logic [GPR_ADDR_WD-1:0] rd;
    logic [CSR_ADDR_WD-1:0] csr;
    logic                   gpr_wen;
    logic                   csr_wen;
    logic                   mem_ren;
    mem_op_e                mem_op;
    logic                   csr_inst;
    logic [XLEN-1:0]        csrrdata;
    logic [XLEN-1:0]        alu_result;
    logic [XLEN-1:0]        csr_result;
  } es_to_ms_t;

  typedef struct packed {
    logic [GPR_ADDR_WD-1:0] rd;
    logic [XLEN-1:0]        gpr_data;
    logic [CSR_ADDR_WD-1:0] csr;
    logic [XLEN-1:0]        csr_data;
  } bypass_t;

  typedef struct packed {
    logic [SRAM_ADDR_WD-1:0]  addr;
    logic                     ren;
    logic                     wen;
    logic [SRAM_WMASK_WD-1:0] wmask;
    logic [XLEN-1:0]          wdata;
  } sram_req_t;

endpackage

//--- hw/ex_stage.sv
// Execute stage

`timescale 1ns/1ps

module ex_stage (
  input  logic              i_clk,
  input  logic              i_rst_n,
  input  logic              i_ds_to_es_valid,
  input  ex_pkg::ds_to_es_t i_ds_to_es_bus,
  output logic              o_es_allowin,
  output logic              o_es_to_ms_valid,
  output ex_pkg::es_to_ms_t o_es_to_ms_bus,
  input  logic              i_ms_allowin,
  output ex_pkg::sram_req_t o_data_sram_req,
  input  logic              i_data_sram_addr_ok,
  output logic              o_es_to_ds_load_sel,
  output ex_pkg::bypass_t   o_es_to_ds_bypass
);

  import ex_pkg::*;

  ds_to_es_t       es_inst;
  logic            es_valid;
  logic            es_mem_inst;
  logic            es_ready_go;
  logic [XLEN-1:0] es_alu_result;
  logic [XLEN-1:0] es_csr_result;
  logic            st_misaligned;

  // memory ops wait for the sram to take the address
  assign es_mem_inst      = es_inst.mem_ren | es_inst.mem_wen;
  assign es_ready_go      = es_mem_inst ? i_data_sram_addr_ok : 1'b1;
  assign o_es_to_ms_valid = es_valid & es_ready_go;

  ex_pipe_reg #(
    .payload_t   (ds_to_es_t)
  ) u_ds_latch (
    .i_clk       (i_clk),
    .i_rst_n     (i_rst_n),
    .i_valid     (i_ds_to_es_valid),
    .i_data      (i_ds_to_es_bus),
    .o_allowin   (o_es_allowin),
    .i_out_ready (es_ready_go & i_ms_allowin),
    .o_valid     (es_valid),
    .o_data      (es_inst)
  );

  ex_alu_csr u_alu_csr (
    .i_inst       (es_inst),
    .o_alu_result (es_alu_result),
    .o_csr_result (es_csr_result)
  );

  ex_store_align u_store_align (
    .i_mem_op   (es_inst.mem_op),
    .i_addr_low (es_alu_result[2:0]),
    .i_rs2data  (es_inst.rs2data),
    .o_wmask    (o_data_sram_req.wmask),
    .o_wdata    (o_data_sram_req.wdata)
  );

  assign o_data_sram_req.addr = es_alu_result[SRAM_ADDR_WD-1:0];   // rs1 + imm
  assign o_data_sram_req.ren  = es_valid & es_inst.mem_ren & i_ms_allowin;
  assign o_data_sram_req.wen  = es_valid & es_inst.mem_wen & i_ms_allowin;

  always_comb begin
    o_es_to_ms_bus.rd         = es_inst.rd;
    o_es_to_ms_bus.csr        = es_inst.csr;
    o_es_to_ms_bus.gpr_wen    = es_inst.gpr_wen;
    o_es_to_ms_bus.csr_wen    = es_inst.csr_wen;
    o_es_to_ms_bus.mem_ren    = es_inst.mem_ren;
    o_es_to_ms_bus.mem_op     = es_inst.mem_op;
    o_es_to_ms_bus.csr_inst   = es_inst.csr_inst;
    o_es_to_ms_bus.csrrdata   = es_inst.csrrdata;
    o_es_to_ms_bus.alu_result = es_alu_result;
    o_es_to_ms_bus.csr_result = es_csr_result;
  end

  assign o_es_to_ds_load_sel = es_valid & es_inst.load_inst;

  always_comb begin
    o_es_to_ds_bypass = '0;
    if (es_valid && es_inst.gpr_wen) begin
      o_es_to_ds_bypass.rd       = es_inst.rd;
      // csr reads hand the old csr value to rd
      o_es_to_ds_bypass.gpr_data = es_inst.csr_inst ? es_inst.csrrdata : es_alu_result;
    end
    if (es_valid && es_inst.csr_wen) begin
      o_es_to_ds_bypass.csr      = es_inst.csr;
      o_es_to_ds_bypass.csr_data = es_csr_result;
    end
  end

  always_comb begin
    case (es_inst.mem_op[1:0])
      2'd1:    st_misaligned = es_alu_result[0];
      2'd2:    st_misaligned = |es_alu_result[1:0];
      2'd3:    st_misaligned = |es_alu_result[2:0];
      default: st_misaligned = 1'b0;
    endcase
  end

  // payload held by the latch while addr_ok is pending
  a_req_stable: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    es_valid && es_mem_inst && !i_data_sram_addr_ok |=>
      $stable(o_data_sram_req.addr) && $stable(o_data_sram_req.wmask) &&
      $stable(o_data_sram_req.wdata));

  a_no_rw: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    !(o_data_sram_req.ren && o_data_sram_req.wen));

  a_store_aligned: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    o_data_sram_req.wen |-> !st_misaligned)
    else $error("misaligned store at %h", o_data_sram_req.addr);

endmodule

//--- hw/ex_store_align.sv
// Store lane alignment

`timescale 1ns/1ps

module ex_store_align (
  input  ex_pkg::mem_op_e                  i_mem_op,
  input  logic [2:0]                       i_addr_low,
  input  logic [ex_pkg::XLEN-1:0]          i_rs2data,
  output logic [ex_pkg::SRAM_WMASK_WD-1:0] o_wmask,
  output logic [ex_pkg::XLEN-1:0]          o_wdata
);

  import ex_pkg::*;

  logic [SRAM_WMASK_WD-1:0] size_mask;

  // size from the low two op bits
  always_comb begin
    case (i_mem_op[1:0])
      2'd0:    size_mask = 8'h01;
      2'd1:    size_mask = 8'h03;
      2'd2:    size_mask = 8'h0f;
      default: size_mask = 8'hff;
    endcase
  end

  assign o_wmask = size_mask << i_addr_low;
  assign o_wdata = i_rs2data << {i_addr_low, 3'b000};   // byte lanes

endmodule

//--- hw/ex_top.sv
// Execute subsystem top

`timescale 1ns/1ps

module ex_top (
  input  logic              i_clk,
  input  logic              i_rst_n,
  input  logic              i_ds_to_es_valid,
  input  ex_pkg::ds_to_es_t i_ds_to_es_bus,
  output logic              o_es_allowin,
  output ex_pkg::sram_req_t o_data_sram_req,
  input  logic              i_data_sram_addr_ok,
  output logic              o_es_to_ds_load_sel,
  output ex_pkg::bypass_t   o_es_to_ds_bypass,
  output logic              o_ms_valid,
  output ex_pkg::es_to_ms_t o_ms_bus,
  input  logic              i_ms_allowin
);

  import ex_pkg::*;

  logic      es_to_ms_valid;
  es_to_ms_t es_to_ms_bus;
  logic      ms_allowin;

  ex_stage u_ex_stage (
    .i_clk               (i_clk),
    .i_rst_n             (i_rst_n),
    .i_ds_to_es_valid    (i_ds_to_es_valid),
    .i_ds_to_es_bus      (i_ds_to_es_bus),
    .o_es_allowin        (o_es_allowin),
    .o_es_to_ms_valid    (es_to_ms_valid),
    .o_es_to_ms_bus      (es_to_ms_bus),
    .i_ms_allowin        (ms_allowin),
    .o_data_sram_req     (o_data_sram_req),
    .i_data_sram_addr_ok (i_data_sram_addr_ok),
    .o_es_to_ds_load_sel (o_es_to_ds_load_sel),
    .o_es_to_ds_bypass   (o_es_to_ds_bypass)
  );

  // memory stage input latch
  ex_pipe_reg #(
    .payload_t   (es_to_ms_t)
  ) u_ms_latch (
    .i_clk       (i_clk),
    .i_rst_n     (i_rst_n),
    .i_valid     (es_to_ms_valid),
    .i_data      (es_to_ms_bus),
    .o_allowin   (ms_allowin),
    .i_out_ready (i_ms_allowin),   // downstream of mem
    .o_valid     (o_ms_valid),
    .o_data      (o_ms_bus)
  );

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the execute subsystem testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --top-module tb_ex_top -f build.f \
  --Mdir obj_dir -o tb_ex_top
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

./obj_dir/tb_ex_top > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "Test failures found" "$LOG"; then
  exit 1
fi
exit 0

//--- test/tb_ex_top.sv
// Execute subsystem testbench

`timescale 1ns/1ps

module tb_ex_top;

  import ex_pkg::*;

  localparam int RESET_CYCLES = 8;
  localparam int N_ALU = 132;
  localparam int N_CSR = 12;
  localparam int N_ST  = 15;
  localparam int N_LD  = 8;
  localparam int N_MIX = 24;
  // worst case cycles for a plain, a memory and a stalled instruction
  localparam int CYCLE_LIMIT = 2 * (RESET_CYCLES + 5 * (N_ALU + N_CSR) +
                                    9 * (N_ST + N_LD) + 16 * N_MIX);

  logic      i_clk = 1'b0;
  logic      i_rst_n;
  logic      i_ds_to_es_valid;
  ds_to_es_t i_ds_to_es_bus;
  logic      o_es_allowin;
  sram_req_t o_data_sram_req;
  logic      i_data_sram_addr_ok = 1'b0;
  logic      o_es_to_ds_load_sel;
  bypass_t   o_es_to_ds_bypass;
  logic      o_ms_valid;
  es_to_ms_t o_ms_bus;
  logic      i_ms_allowin = 1'b1;

  logic [31:0] lfsr_state = 32'h71a5fe66;
  string       test_name = "";
  int          n_mismatch = 0;
  int          n_other = 0;
  int          cyc = 0;
  logic        stall_en = 1'b0;
  logic        check_latency = 1'b0;
  logic        sram_busy = 1'b0;
  logic        sram_take = 1'b0;
  int          ok_delay = -1;
  logic        hold_prev = 1'b0;
  es_to_ms_t   held_bus;
  es_to_ms_t   exp_bus;
  int          present;
  es_to_ms_t   exp_out_q[$];
  int          present_q[$];
  sram_req_t   exp_req_q[$];

  ex_top dut0 (
    .i_clk               (i_clk),
    .i_rst_n             (i_rst_n),
    .i_ds_to_es_valid    (i_ds_to_es_valid),
    .i_ds_to_es_bus      (i_ds_to_es_bus),
    .o_es_allowin        (o_es_allowin),
    .o_data_sram_req     (o_data_sram_req),
    .i_data_sram_addr_ok (i_data_sram_addr_ok),
    .o_es_to_ds_load_sel (o_es_to_ds_load_sel),
    .o_es_to_ds_bypass   (o_es_to_ds_bypass),
    .o_ms_valid          (o_ms_valid),
    .o_ms_bus            (o_ms_bus),
    .i_ms_allowin        (i_ms_allowin)
  );

  always #50 i_clk = ~i_clk;

  // galois form of x^32 + x^22 + x^2 + x + 1
  function automatic logic next_rand_bit();
    logic lsb;
    lsb = lfsr_state[0];
    lfsr_state = lfsr_state >> 1;
    if (lsb) lfsr_state = lfsr_state ^ 32'h80200003;
    return lsb;
  endfunction

  function automatic logic [63:0] rand_bits(input int n);
    logic [63:0] v;
    v = '0;
    for (int i = 0; i < n; i++) v = {v[62:0], next_rand_bit()};
    return v;
  endfunction

  function automatic int unsigned rand_num(input int n);
    return 32'(rand_bits(n));
  endfunction

  function automatic int aligned_offset(input int size);
    return int'(rand_num(3)) & ~((1 << size) - 1);
  endfunction

  function automatic logic [63:0] alu_model(input ds_to_es_t t);
    logic [63:0] a;
    logic [63:0] b;
    logic [63:0] r;
    logic [31:0] w;
    int          sh;
    a = t.src1_is_pc ? t.pc : t.rs1data;
    case (t.src2_sel)
      SRC2_RS2: b = t.rs2data;
      SRC2_IMM: b = t.imm;
      default:  b = 64'd4;
    endcase
    sh = t.word_cut ? int'(b[4:0]) : int'(b[5:0]);
    case (t.alu_op)
      ALU_ADD:  r = a + b;
      ALU_SUB:  r = a - b;
      ALU_SLL:  r = a << sh;
      ALU_SLT:  r = ($signed(a) < $signed(b)) ? 64'd1 : 64'd0;
      ALU_SLTU: r = (a < b) ? 64'd1 : 64'd0;
      ALU_XOR:  r = a ^ b;
      ALU_OR:   r = a | b;
      ALU_AND:  r = a & b;
      ALU_SRL: begin
        w = a[31:0] >> sh;
        r = t.word_cut ? {32'b0, w} : a >> sh;
      end
      ALU_SRA: begin
        w = $signed(a[31:0]) >>> sh;
        r = t.word_cut ? {32'b0, w} : 64'($signed(a) >>> sh);
      end
      default:  r = b;
    endcase
    if (t.word_cut) r = {{32{r[31]}}, r[31:0]};
    return r;
  endfunction

  function automatic logic [63:0] csr_model(input ds_to_es_t t);
    case (t.csr_op)
      CSR_RW:  return t.rs1data;
      CSR_RS:  return t.csrrdata | t.rs1data;
      CSR_RC:  return t.csrrdata & ~t.rs1data;
      default: return 64'd0;
    endcase
  endfunction

  function automatic es_to_ms_t ms_model(input ds_to_es_t t);
    es_to_ms_t m;
    m.rd         = t.rd;
    m.csr        = t.csr;
    m.gpr_wen    = t.gpr_wen;
    m.csr_wen    = t.csr_wen;
    m.mem_ren    = t.mem_ren;
    m.mem_op     = t.mem_op;
    m.csr_inst   = t.csr_inst;
    m.csrrdata   = t.csrrdata;
    m.alu_result = alu_model(t);
    m.csr_result = csr_model(t);
    return m;
  endfunction

  function automatic sram_req_t req_model(input ds_to_es_t t);
    sram_req_t   r;
    logic [63:0] sum;
    logic [15:0] size_bits;
    int          off;
    sum = alu_model(t);
    off = int'(sum[2:0]);
    size_bits = (16'd1 << (1 << int'(t.mem_op[1:0]))) - 16'd1;
    r.addr  = sum[31:0];
    r.ren   = t.mem_ren;
    r.wen   = t.mem_wen;
    r.wmask = size_bits[7:0] << off;
    r.wdata = t.rs2data << (8 * off);
    return r;
  endfunction

  function automatic bypass_t bypass_model(input ds_to_es_t t);
    bypass_t b;
    b = '0;
    if (t.gpr_wen) begin
      b.rd       = t.rd;
      b.gpr_data = t.csr_inst ? t.csrrdata : alu_model(t);
    end
    if (t.csr_wen) begin
      b.csr      = t.csr;
      b.csr_data = csr_model(t);
    end
    return b;
  endfunction

  function automatic ds_to_es_t base_inst();
    ds_to_es_t t;
    t = '0;
    t.rs1data  = rand_bits(64);
    t.rs2data  = rand_bits(64);
    t.csrrdata = rand_bits(64);
    t.imm      = rand_bits(64);
    t.pc       = rand_bits(64);
    t.rd       = GPR_ADDR_WD'(rand_num(5));
    t.csr      = CSR_ADDR_WD'(rand_num(12));
    return t;
  endfunction

  function automatic ds_to_es_t alu_inst(input alu_op_e op, input logic wc, input logic s1,
                                         input src2_sel_e s2);
    ds_to_es_t t;
    t = base_inst();
    t.alu_op     = op;
    t.word_cut   = wc;
    t.src1_is_pc = s1;
    t.src2_sel   = s2;
    t.gpr_wen    = 1'b1;
    return t;
  endfunction

  function automatic ds_to_es_t csr_access(input csr_op_e op, input logic gw, input logic cw);
    ds_to_es_t t;
    t = base_inst();
    t.csr_inst = 1'b1;
    t.csr_op   = op;
    t.gpr_wen  = gw;
    t.csr_wen  = cw;
    return t;
  endfunction

  function automatic ds_to_es_t mem_access(input logic is_load, input mem_op_e mop,
                                           input int off);
    ds_to_es_t t;
    t = base_inst();
    t.rs1data   = t.rs1data & ~64'h7;   // base on a double boundary
    t.imm       = 64'(off);
    t.src2_sel  = SRC2_IMM;
    t.mem_op    = mop;
    t.load_inst = is_load;
    t.mem_ren   = is_load;
    t.gpr_wen   = is_load;
    t.mem_wen   = !is_load;
    return t;
  endfunction

  task automatic report(input string msg);
    $display("%s: %s", test_name, msg);
    n_other++;
  endtask

  task automatic flag_matches(input string what, input logic exp, input logic act);
    if (act !== exp) begin
      $display("Fail %s %s: expected %b actual %b", test_name, what, exp, act);
      n_mismatch++;
    end
  endtask

  task automatic ms_matches(input string what, input es_to_ms_t exp, input es_to_ms_t act);
    if (act !== exp) begin
      $display("Fail %s %s: expected %h actual %h", test_name, what, exp, act);
      n_mismatch++;
    end
  endtask

  task automatic req_matches(input string what, input sram_req_t exp, input sram_req_t act);
    if (act !== exp) begin
      $display("Fail %s %s: expected %h actual %h", test_name, what, exp, act);
      n_mismatch++;
    end
  endtask

  task automatic bypass_matches(input string what, input bypass_t exp, input bypass_t act);
    if (act !== exp) begin
      $display("Fail %s %s: expected %h actual %h", test_name, what, exp, act);
      n_mismatch++;
    end
  endtask

  // present one instruction and wait for the stage to take it
  task automatic issue(input ds_to_es_t inst);
    @(posedge i_clk);
    i_ds_to_es_valid <= 1'b1;
    i_ds_to_es_bus   <= inst;
    @(negedge i_clk);
    while (!o_es_allowin) @(negedge i_clk);
    exp_out_q.push_back(ms_model(inst));
    present_q.push_back(cyc);
    if (inst.mem_ren || inst.mem_wen) exp_req_q.push_back(req_model(inst));
    @(posedge i_clk);
    i_ds_to_es_valid <= 1'b0;
  endtask

  task automatic drain();
    while (exp_out_q.size() != 0 || exp_req_q.size() != 0) @(negedge i_clk);
  endtask

  task automatic reset_values();
    test_name = "reset";
    flag_matches("o_ms_valid", 1'b0, o_ms_valid);
    flag_matches("ren", 1'b0, o_data_sram_req.ren);
    flag_matches("wen", 1'b0, o_data_sram_req.wen);
    flag_matches("load_sel", 1'b0, o_es_to_ds_load_sel);
    bypass_matches("bypass", '0, o_es_to_ds_bypass);
    flag_matches("o_es_allowin", 1'b1, o_es_allowin);
  endtask

  task automatic alu_ops();
    ds_to_es_t t;
    test_name = "alu";
    check_latency = 1'b1;
    for (int op = 0; op < 11; op++)
      for (int wc = 0; wc < 2; wc++)
        for (int s1 = 0; s1 < 2; s1++)
          for (int s2 = 0; s2 < 3; s2++) begin
            t = alu_inst(alu_op_e'(4'(op)), 1'(wc), 1'(s1), src2_sel_e'(2'(s2)));
            issue(t);
            @(negedge i_clk);   // still in execute
            bypass_matches("bypass", bypass_model(t), o_es_to_ds_bypass);
            drain();
          end
    check_latency = 1'b0;
  endtask

  task automatic csr_ops();
    ds_to_es_t t;
    test_name = "csr";
    for (int op = 1; op < 4; op++)
      for (int en = 0; en < 4; en++) begin
        t = csr_access(csr_op_e'(2'(op)), en[0], en[1]);
        issue(t);
        @(negedge i_clk);   // now held in execute
        bypass_matches("bypass", bypass_model(t), o_es_to_ds_bypass);
        drain();
      end
  endtask

  task automatic store_sizes();
    test_name = "store";
    for (int s = 0; s < 4; s++)
      for (int off = 0; off < 8; off += (1 << s)) begin
        issue(mem_access(1'b0, mem_op_e'(3'(s)), off));
        drain();
      end
  endtask

  task automatic load_waits();
    int   m;
    logic waiting;
    test_name = "load";
    repeat (N_LD) begin
      m = int'(rand_num(3) % 7);
      issue(mem_access(1'b1, mem_op_e'(3'(m)), aligned_offset(m & 3)));
      waiting = 1'b1;
      while (waiting) begin
        @(negedge i_clk);
        if (i_data_sram_addr_ok) begin
          waiting = 1'b0;
        end else begin
          flag_matches("load_sel while waiting", 1'b1, o_es_to_ds_load_sel);
          flag_matches("allowin while waiting", 1'b0, o_es_allowin);
        end
      end
    end
    drain();
  endtask

  task automatic mixed_stalls();
    ds_to_es_t t;
    int        kind;
    int        m;
    test_name = "mixed";
    stall_en = 1'b1;
    repeat (N_MIX) begin
      @(negedge i_clk);   // draw operands mid-cycle
      kind = int'(rand_num(2));
      case (kind)
        0: t = alu_inst(alu_op_e'(4'(rand_num(4) % 11)), rand_num(1) != 0,
                        rand_num(1) != 0, src2_sel_e'(2'(rand_num(2) % 3)));
        1: t = csr_access(csr_op_e'(2'(rand_num(2) % 3 + 1)), rand_num(1) != 0,
                          rand_num(1) != 0);
        2: begin
          m = int'(rand_num(3) % 7);
          t = mem_access(1'b1, mem_op_e'(3'(m)), aligned_offset(m & 3));
        end
        default: begin
          m = int'(rand_num(2));
          t = mem_access(1'b0, mem_op_e'(3'(m)), aligned_offset(m));
        end
      endcase
      issue(t);
    end
    drain();
    stall_en = 1'b0;
  endtask

  // sram acceptance model
  always @(negedge i_clk) begin
    sram_busy = i_rst_n && (o_data_sram_req.ren || o_data_sram_req.wen);
    sram_take = sram_busy && i_data_sram_addr_ok;
    if (sram_take) begin
      if (exp_req_q.size() == 0) report("SRAM accepted a request that no instruction made");
      else req_matches("sram request", exp_req_q.pop_front(), o_data_sram_req);
    end
  end

  always @(posedge i_clk) begin
    if (!sram_busy || sram_take) begin
      i_data_sram_addr_ok <= 1'b0;
      ok_delay = -1;
    end else begin
      if (ok_delay < 0) ok_delay = int'(rand_num(2));   // 0 to 3 cycles
      if (ok_delay == 0) i_data_sram_addr_ok <= 1'b1;
      else ok_delay = ok_delay - 1;
    end
    if (stall_en) i_ms_allowin <= (rand_num(2) != 0);
    else i_ms_allowin <= 1'b1;
  end

  // memory latch output checked in issue order
  always @(negedge i_clk) begin
    if (i_rst_n) begin
      if (hold_prev) begin
        if (!o_ms_valid) report("o_ms_valid dropped during a stall");
        ms_matches("held bus", held_bus, o_ms_bus);
      end
      hold_prev = o_ms_valid && !i_ms_allowin;
      held_bus  = o_ms_bus;
      if (o_ms_valid && i_ms_allowin) begin
        if (exp_out_q.size() == 0) begin
          report("an item left the memory latch that was never issued");
        end else begin
          exp_bus = exp_out_q.pop_front();
          present = present_q.pop_front();
          ms_matches("ms bus", exp_bus, o_ms_bus);
          if (check_latency && cyc - present != 2)
            report($sformatf("o_ms_valid came %0d edges after issue, not 2", cyc - present));
        end
      end
    end
  end

  always @(posedge i_clk) begin
    cyc <= cyc + 1;
    if (cyc >= CYCLE_LIMIT) begin
      $display("timeout after %0d cycles in test %s", cyc, test_name);
      $display("Test failures found");
      $finish;
    end
  end

  initial begin
    i_rst_n          = 1'b0;
    i_ds_to_es_valid = 1'b0;
    i_ds_to_es_bus   = '0;
    repeat (RESET_CYCLES) @(posedge i_clk);
    i_rst_n <= 1'b1;
    @(negedge i_clk);
    reset_values();
    alu_ops();
    csr_ops();
    store_sizes();
    load_waits();
    mixed_stalls();
    $display("errors: %0d mismatches, %0d other failures", n_mismatch, n_other);
    if (n_mismatch + n_other == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule
